//--- sources.f
hdl/tx_pkg.sv
hdl/tx_policy_reg.sv
hdl/tx_time_base.sv
hdl/tx_rate_strobe.sv
hdl/tx_burst_control.sv
hdl/tx_subsystem.sv
verif/tb_clock.sv
verif/tb_tx_subsystem.sv

//--- Bender.yml
package:
  name: tx_burst_control

sources:
  - hdl/tx_pkg.sv
  - hdl/tx_policy_reg.sv
  - hdl/tx_time_base.sv
  - hdl/tx_rate_strobe.sv
  - hdl/tx_burst_control.sv
  - hdl/tx_subsystem.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_tx_subsystem.sv

//--- verif/tb_tx_subsystem.sv
`timescale 1ns/1ps

module tb_tx_subsystem
   import tx_pkg::*;
();

   logic        clk;
   logic        rst_n;
   logic        clear;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   tx_sample_t  sample_tdata;
   logic        sample_tvalid;
   logic        sample_tready;
   logic        packet_consumed;
   logic [31:0] sample;
   logic        run;
   logic        strobe;
   logic [31:0] sid;
   tx_ack_t     ack;
   logic [63:0] vita_time;
   logic [31:0] debug;

   tx_sample_t       word_q[$];
   int               stall_q[$];
   int               stall_left;
   bit               head_new = 1'b1;
   int               words_pushed = 0;
   int               cycles = 0;
   int               errors = 0;
   int               err_at_start;
   int               passed = 0;
   int               failed = 0;
   int               rate_now = 0;
   logic [SEQ_W-1:0] next_seq = '0;
   int               n_eob;
   int               n_under;
   int               n_seq;
   int               n_time;
   int               n_mid;

   // reference model state
   tx_ctrl_state_e   m_state;
   logic [SEQ_W-1:0] m_exp;
   logic             m_armed;
   logic             m_pchg;
   logic             m_pnp;
   logic             m_pnb;
   logic [63:0]      m_time;
   logic [31:0]      m_hi;
   logic [31:0]      m_rate;
   logic [31:0]      m_count;
   logic             m_ack_v;
   logic [63:0]      m_ack_code;

   tb_clock i_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   tx_subsystem i_dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .clear           (clear),
      .set_stb         (set_stb),
      .set_addr        (set_addr),
      .set_data        (set_data),
      .sample_tdata    (sample_tdata),
      .sample_tvalid   (sample_tvalid),
      .sample_tready   (sample_tready),
      .packet_consumed (packet_consumed),
      .sample          (sample),
      .run             (run),
      .strobe          (strobe),
      .sid             (sid),
      .ack             (ack),
      .vita_time       (vita_time),
      .debug           (debug)
   );

   task automatic check(input string name, input logic [63:0] actual,
                        input logic [63:0] expected);
      if (actual !== expected)
      begin
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   function automatic logic [63:0] plain(input logic [31:0] kind, input logic [SEQ_W-1:0] rcv);
      return {kind, 20'd0, rcv};
   endfunction

   function automatic logic [63:0] seq_view(input logic [31:0] kind,
                                            input logic [SEQ_W-1:0] exp,
                                            input logic [SEQ_W-1:0] rcv);
      return {kind, 4'd0, exp, 4'd0, rcv};
   endfunction

   // one cycle of the expected behaviour, fed with the values of the ending cycle
   task automatic model_step();
      tx_sample_t     w;
      tx_ctrl_state_e nxt;
      logic           m_run;
      logic           m_strobe;
      logic           start;
      logic           ready;
      logic           consumed;
      logic           to_clear;
      logic           ack_v;
      logic [63:0]    code;
      logic [31:0]    dbg;
      w        = sample_tdata;
      m_run    = (m_state == SAMP0) || (m_state == SAMP1);
      m_strobe = m_run && (m_count == m_rate);
      check("strobe", strobe, m_strobe);
      check("run", run, m_run);
      check("vita_time", vita_time, m_time);
      if (m_strobe && sample_tvalid)
      begin
         check("sample", sample, (m_state == SAMP0) ? w.sample0 : w.sample1);
         check("sid", sid, w.sid);
      end
      check("ack.valid", ack.valid, m_ack_v);
      if (m_ack_v)
      begin
         check("ack.code", ack.code, m_ack_code);
      end
      start = !w.send_at || (m_time == w.send_time);
      nxt   = m_state;
      ready = 1'b0;
      ack_v = 1'b0;
      code  = plain(KIND_EOB_ACK, w.seqnum);
      case (m_state)
         IDLE:
         begin
            if (sample_tvalid && start)
            begin
               nxt = (w.seqnum == m_exp) ? SAMP0 : ERROR;
               ack_v = (w.seqnum != m_exp);
               code  = seq_view(KIND_SEQ_ERROR, m_exp, w.seqnum);
            end
            else if (sample_tvalid && (m_time > w.send_time))
            begin
               nxt   = ERROR;
               ack_v = 1'b1;
               code  = plain(KIND_TIME_ERROR, w.seqnum);
            end
         end
         SAMP0:
         begin
            if (m_strobe && !sample_tvalid)
            begin
               nxt   = ERROR;
               ack_v = 1'b1;
               code  = plain(KIND_UNDERRUN, w.seqnum);
            end
            else if (m_strobe && w.eop && w.odd)
            begin
               ready = 1'b1; // single-sample final word
               ack_v = w.eob;
               nxt   = w.eob ? IDLE : SAMP0;
            end
            else if (m_strobe && (w.seqnum != m_exp))
            begin
               nxt   = ERROR;
               ack_v = 1'b1;
               code  = seq_view(KIND_SEQ_ERROR_MIDBURST, m_exp, w.seqnum);
            end
            else if (m_strobe)
            begin
               nxt = SAMP1;
            end
         end
         SAMP1:
         begin
            if (m_strobe)
            begin
               ready = 1'b1;
               ack_v = w.eop && w.eob;
               nxt   = (w.eop && w.eob) ? IDLE : SAMP0;
            end
         end
         default:
         begin
            ready = 1'b1;
            if (sample_tvalid && w.eop && (m_pnp || (m_pnb && w.eob)))
            begin
               nxt = IDLE;
            end
         end
      endcase
      check("sample_tready", sample_tready, ready);
      // debug word, last code and flags above the state
      dbg = {1'b0, m_ack_code[37:32], m_ack_code[11:0], sample_tvalid,
             (m_time == w.send_time), (m_time > w.send_time), m_strobe,
             w.eop, w.eob, w.send_at, w.odd, ready, m_armed, m_ack_v, m_state};
      check("debug", debug, dbg);
      consumed = sample_tvalid && ready && w.eop;
      check("packet_consumed", packet_consumed, consumed);
      to_clear = m_armed && ((consumed && w.eob) || (m_state == ERROR) ||
                             ((m_state == IDLE) && sample_tvalid && !start));
      if (m_pchg)
      begin
         m_armed = 1'b1;
      end
      if (to_clear)
      begin
         m_exp   = '0;
         m_armed = 1'b0;
      end
      else if (consumed)
      begin
         m_exp = w.seqnum + 1'b1;
      end
      m_count = (!m_run || (m_count == m_rate)) ? 32'd0 : m_count + 32'd1;
      if (set_stb && (set_addr == ADDR_TIME_LO))
      begin
         m_time = {m_hi, set_data};
      end
      else
      begin
         m_time = m_time + 64'd1;
      end
      if (set_stb && (set_addr == ADDR_TIME_HI))
      begin
         m_hi = set_data;
      end
      if (set_stb && (set_addr == ADDR_RATE))
      begin
         m_rate = set_data;
      end
      m_pchg = set_stb && (set_addr == ADDR_POLICY);
      if (m_pchg)
      begin
         m_pnp = set_data[1];
         m_pnb = set_data[2];
      end
      m_state = nxt;
      m_ack_v = ack_v;
      if (ack_v)
      begin
         m_ack_code = code;
      end
   endtask

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         m_state    = IDLE;
         m_exp      = '0;
         m_armed    = 1'b0;
         m_pchg     = 1'b0;
         m_pnp      = 1'b0;
         m_pnb      = 1'b0;
         m_time     = '0;
         m_hi       = '0;
         m_rate     = '0;
         m_count    = '0;
         m_ack_v    = 1'b0;
         m_ack_code = '0;
      end
      else
      begin
         model_step();
         if (ack.valid)
         begin
            case (ack.code[63:32])
               KIND_EOB_ACK:            n_eob++;
               KIND_UNDERRUN:           n_under++;
               KIND_SEQ_ERROR:          n_seq++;
               KIND_TIME_ERROR:         n_time++;
               KIND_SEQ_ERROR_MIDBURST: n_mid++;
               default:                 check("ack kind", ack.code[63:32], 32'd0);
            endcase
         end
      end
   end

   // source, pops the head on a handshake and inserts stalls
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (sample_tvalid && sample_tready)
         begin
            void'(word_q.pop_front());
            void'(stall_q.pop_front());
            head_new = 1'b1;
         end
         if (word_q.size() > 0)
         begin
            if (head_new)
            begin
               stall_left = stall_q[0];
               head_new   = 1'b0;
            end
            sample_tdata  <= word_q[0];
            sample_tvalid <= (stall_left == 0);
            if (stall_left > 0)
            begin
               stall_left--;
            end
         end
         else
         begin
            sample_tvalid <= 1'b0;
            head_new = 1'b1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > 200 * words_pushed + 2000)
      begin
         $display("timeout: run stopped after %0d cycles with %0d words still queued",
                  cycles, word_q.size());
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge clk);
      set_stb  <= 1'b0;
   endtask

   // gap_pkt and stall_pkt select a packet, -1 for none
   task automatic push_burst(input int npk, input bit timed, input logic [63:0] t,
                             input int gap_pkt, input int stall_pkt);
      tx_sample_t       w;
      int               nw;
      logic [SEQ_W-1:0] seq;
      for (int p = 0; p < npk; p++)
      begin
         nw  = 1 + $urandom % 6;
         seq = next_seq;
         if (p == gap_pkt)
         begin
            seq = seq + 1 + $urandom % 5;
         end
         next_seq = seq + 1'b1;
         for (int i = 0; i < nw; i++)
         begin
            w.eop       = (i == nw - 1);
            w.eob       = w.eop && (p == npk - 1);
            w.odd       = w.eop && (p != gap_pkt) && ($urandom % 2);
            w.send_at   = timed && (p == 0) && (i == 0);
            w.seqnum    = seq;
            w.sid       = $urandom;
            w.send_time = t;
            w.sample0   = $urandom;
            w.sample1   = $urandom;
            word_q.push_back(w);
            stall_q.push_back((p == stall_pkt && p > 0 && i == 0) ? rate_now + 4 : 0);
            words_pushed++;
         end
      end
   endtask

   task automatic wait_drained();
      while (word_q.size() > 0 || sample_tvalid || m_state != IDLE)
      begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk); // let the last ack pulse through
   endtask

   task automatic set_rate(input int r);
      write_setting(ADDR_RATE, r);
      rate_now = r;
   endtask

   // a policy write arms the clear, the next eob then zeroes the expected seqnum
   task automatic set_policy(input logic [2:0] bits);
      write_setting(ADDR_POLICY, {29'd0, bits});
      push_burst(1 + $urandom % 2, 1'b0, 64'd0, -1, -1);
      wait_drained();
      next_seq = '0;
   endtask

   task automatic begin_test();
      err_at_start = errors;
      n_eob   = 0;
      n_under = 0;
      n_seq   = 0;
      n_time  = 0;
      n_mid   = 0;
   endtask

   task automatic end_test(input string name);
      if (errors == err_at_start)
      begin
         passed++;
         $display("test %s: pass", name);
      end
      else
      begin
         failed++;
         $display("test %s: fail with %0d errors", name, errors - err_at_start);
      end
   endtask

   initial
   begin
      void'($urandom(32'h55fd_682e));
      clear         <= 1'b0;
      set_stb       <= 1'b0;
      set_addr      <= '0;
      set_data      <= '0;
      sample_tdata  <= '0;
      sample_tvalid <= 1'b0;
      @(posedge rst_n);
      @(posedge clk);
      set_policy(3'b010);

      begin_test();
      for (int r = 0; r < 2; r++)
      begin
         set_rate(r * 3);
         repeat (3) push_burst(1 + $urandom % 4, 1'b0, 64'd0, -1, -1);
         wait_drained();
      end
      check("eob ack count", n_eob, 6);
      end_test("untimed bursts");

      begin_test();
      write_setting(ADDR_TIME_HI, 32'd0);
      write_setting(ADDR_TIME_LO, 32'h0000_1000);
      push_burst(1 + $urandom % 4, 1'b1, 64'h1000 + 40 + $urandom % 20, -1, -1);
      wait_drained();
      push_burst(2, 1'b1, 64'h1000, -1, -1); // already late
      wait_drained();
      check("eob ack count", n_eob, 2); // second packet resumes after the time error
      check("time error count", n_time, 1);
      end_test("timed bursts");

      begin_test();
      push_burst(2, 1'b0, 64'd0, 0, -1);
      wait_drained();
      push_burst(3, 1'b0, 64'd0, 1, -1);
      wait_drained();
      check("seq error count", n_seq, 1);
      check("midburst error count", n_mid, 1);
      end_test("sequence errors");

      begin_test();
      push_burst(3, 1'b0, 64'd0, -1, 1);
      wait_drained();
      check("underrun count", n_under, 1);
      end_test("underrun");

      begin_test();
      push_burst(3, 1'b0, 64'd0, 1, -1);
      wait_drained();
      check("next_packet eob count", n_eob, 1);
      set_policy(3'b100);
      n_eob = 0;
      push_burst(3, 1'b0, 64'd0, 1, -1);
      wait_drained();
      check("next_burst eob count", n_eob, 0);
      push_burst(2, 1'b0, 64'd0, -1, -1);
      wait_drained();
      check("next_burst resume count", n_eob, 1);
      end_test("error policies");

      begin_test();
      set_policy(3'b010);
      push_burst(2, 1'b0, 64'd0, -1, -1); // starts at seqnum zero
      wait_drained();
      check("seq error after clear", n_seq, 0);
      check("eob ack count", n_eob, 2);
      end_test("armed clear");

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (failed == 0 && errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- hdl/tx_subsystem.sv
`timescale 1ns/1ps

module tx_subsystem
   import tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        clear,
   input  logic        set_stb,
   input  logic [7:0]  set_addr,
   input  logic [31:0] set_data,
   input  tx_sample_t  sample_tdata,
   input  logic        sample_tvalid,
   output logic        sample_tready,
   output logic        packet_consumed,
   output logic [31:0] sample,
   output logic        run,
   output logic        strobe,
   output logic [31:0] sid,
   output tx_ack_t     ack,
   output logic [63:0] vita_time,
   output logic [31:0] debug
);

   logic policy_next_packet;
   logic policy_next_burst;
   logic policy_changed;
   logic now;
   logic late;

   // wait policy has no consumer yet
   tx_policy_reg i_policy (
      .clk                (clk),
      .rst_n              (rst_n),
      .set_stb            (set_stb),
      .set_addr           (set_addr),
      .set_data           (set_data),
      .policy_wait        (),
      .policy_next_packet (policy_next_packet),
      .policy_next_burst  (policy_next_burst),
      .policy_changed     (policy_changed)
   );

   tx_time_base i_time (
      .clk       (clk),
      .rst_n     (rst_n),
      .set_stb   (set_stb),
      .set_addr  (set_addr),
      .set_data  (set_data),
      .send_time (sample_tdata.send_time), // head word
      .vita_time (vita_time),
      .now       (now),
      .early     (),
      .late      (late)
   );

   tx_rate_strobe i_strobe (
      .clk      (clk),
      .rst_n    (rst_n),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data),
      .run      (run),
      .strobe   (strobe)
   );

   tx_burst_control i_ctrl (
      .clk                (clk),
      .rst_n              (rst_n),
      .clear              (clear),
      .sample_tdata       (sample_tdata),
      .sample_tvalid      (sample_tvalid),
      .now                (now),
      .late               (late),
      .strobe             (strobe),
      .policy_next_packet (policy_next_packet),
      .policy_next_burst  (policy_next_burst),
      .policy_changed     (policy_changed),
      .sample_tready      (sample_tready),
      .packet_consumed    (packet_consumed),
      .sample             (sample),
      .run                (run),
      .sid                (sid),
      .ack                (ack),
      .debug              (debug)
   );

endmodule

//--- hdl/tx_burst_control.sv
`timescale 1ns/1ps

module tx_burst_control
   import tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        clear,
   input  tx_sample_t  sample_tdata,
   input  logic        sample_tvalid,
   input  logic        now,
   input  logic        late,
   input  logic        strobe,
   input  logic        policy_next_packet,
   input  logic        policy_next_burst,
   input  logic        policy_changed,
   output logic        sample_tready,
   output logic        packet_consumed,
   output logic [31:0] sample,
   output logic        run,
   output logic [31:0] sid,
   output tx_ack_t     ack,
   output logic [31:0] debug
);

   tx_ctrl_state_e   state;
   tx_ctrl_state_e   state_nxt;
   logic [SEQ_W-1:0] expected_seqnum;
   logic             clear_armed;
   logic             ack_valid;
   logic             ack_valid_nxt;
   tx_err_code_u     ack_code;
   tx_err_code_u     ack_code_nxt;
   logic             burst_start;
   logic             seq_ok;
   logic             idle_waiting;
   logic             time_to_clear;

   function automatic tx_err_code_u plain_code(input logic [31:0]      kind,
                                                input logic [SEQ_W-1:0] received);
      tx_err_code_u c;
      c.plain.kind   = kind;
      c.plain.zero   = '0;
      c.plain.seqnum = received;
      return c;
   endfunction

   function automatic tx_err_code_u seq_code(input logic [31:0]      kind,
                                              input logic [SEQ_W-1:0] expected,
                                              input logic [SEQ_W-1:0] received);
      tx_err_code_u c;
      c.seq.kind     = kind;
      c.seq.zero_hi  = '0;
      c.seq.expected = expected;
      c.seq.zero_lo  = '0;
      c.seq.received = received;
      return c;
   endfunction

   assign burst_start  = !sample_tdata.send_at || now;
   assign seq_ok       = (sample_tdata.seqnum == expected_seqnum);
   assign idle_waiting = (state == IDLE) && sample_tvalid && !burst_start;

   // handshake, ready only when a word retires
   always_comb
   begin
      unique case (state)
         ERROR:   sample_tready = 1'b1; // drain
         SAMP1:   sample_tready = strobe;
         SAMP0:   sample_tready = strobe && sample_tvalid &&
                                  sample_tdata.eop && sample_tdata.odd;
         default: sample_tready = 1'b0;
      endcase
   end

   assign packet_consumed = sample_tvalid && sample_tready && sample_tdata.eop;

   assign time_to_clear = clear_armed &&
                          ((packet_consumed && sample_tdata.eob) ||
                           (state == ERROR) ||
                           idle_waiting);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         expected_seqnum <= '0;
         clear_armed     <= 1'b0;
      end
      else if (clear)
      begin
         expected_seqnum <= '0;
         clear_armed     <= 1'b0;
      end
      else
      begin
         if (policy_changed)
         begin
            clear_armed <= 1'b1;
         end
         if (time_to_clear)
         begin
            expected_seqnum <= '0;
            clear_armed     <= 1'b0;
         end
         else if (packet_consumed)
         begin
            expected_seqnum <= sample_tdata.seqnum + 1'b1;
         end
      end
   end

   always_comb
   begin
      state_nxt     = state;
      ack_valid_nxt = 1'b0;
      ack_code_nxt  = plain_code(KIND_EOB_ACK, sample_tdata.seqnum);
      unique case (state)
         IDLE:
         begin
            if (sample_tvalid && burst_start)
            begin
               if (!seq_ok)
               begin
                  state_nxt     = ERROR;
                  ack_valid_nxt = 1'b1;
                  ack_code_nxt  = seq_code(KIND_SEQ_ERROR, expected_seqnum,
                                           sample_tdata.seqnum);
               end
               else
               begin
                  state_nxt = SAMP0;
               end
            end
            else if (sample_tvalid && late)
            begin
               state_nxt     = ERROR;
               ack_valid_nxt = 1'b1;
               ack_code_nxt  = plain_code(KIND_TIME_ERROR, sample_tdata.seqnum);
            end
         end
         SAMP0:
         begin
            if (strobe)
            begin
               if (!sample_tvalid)
               begin
                  state_nxt     = ERROR;
                  ack_valid_nxt = 1'b1;
                  ack_code_nxt  = plain_code(KIND_UNDERRUN, sample_tdata.seqnum);
               end
               else if (sample_tdata.eop && sample_tdata.odd && sample_tdata.eob)
               begin
                  state_nxt     = IDLE;
                  ack_valid_nxt = 1'b1;
               end
               else if (sample_tdata.eop && sample_tdata.odd)
               begin
                  state_nxt = SAMP0; // one-sample word retired
               end
               else if (!seq_ok)
               begin
                  state_nxt     = ERROR;
                  ack_valid_nxt = 1'b1;
                  ack_code_nxt  = seq_code(KIND_SEQ_ERROR_MIDBURST, expected_seqnum,
                                           sample_tdata.seqnum);
               end
               else
               begin
                  state_nxt = SAMP1;
               end
            end
         end
         SAMP1:
         begin
            if (strobe)
            begin
               if (sample_tdata.eop && sample_tdata.eob)
               begin
                  state_nxt     = IDLE;
                  ack_valid_nxt = 1'b1;
               end
               else
               begin
                  state_nxt = SAMP0;
               end
            end
         end
         ERROR:
         begin
            if (sample_tvalid && sample_tdata.eop &&
                (policy_next_packet || (policy_next_burst && sample_tdata.eob)))
            begin
               state_nxt = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= IDLE;
         ack_valid <= 1'b0;
         ack_code  <= '0;
      end
      else if (clear)
      begin
         state     <= IDLE;
         ack_valid <= 1'b0;
         ack_code  <= '0;
      end
      else
      begin
         state     <= state_nxt;
         ack_valid <= ack_valid_nxt;
         if (ack_valid_nxt)
         begin
            ack_code <= ack_code_nxt; // last code stays visible on debug
         end
      end
   end

   assign ack.valid = ack_valid;
   assign ack.code  = ack_code;

   assign run    = (state == SAMP0) || (state == SAMP1);
   assign sample = (state == SAMP0) ? sample_tdata.sample0 : sample_tdata.sample1;
   assign sid    = sample_tdata.sid;

   assign debug = {1'b0,
                   ack_code.plain.kind[5:0],  // [30:25]
                   ack_code.plain.seqnum,     // [24:13]
                   sample_tvalid,             // [12]
                   now,
                   late,
                   strobe,
                   sample_tdata.eop,          // [8]
                   sample_tdata.eob,
                   sample_tdata.send_at,
                   sample_tdata.odd,
                   sample_tready,             // [4]
                   clear_armed,
                   ack_valid,
                   state};                    // [1:0]

endmodule

//--- hdl/tx_rate_strobe.sv
`timescale 1ns/1ps

module tx_rate_strobe
   import tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        set_stb,
   input  logic [7:0]  set_addr,
   input  logic [31:0] set_data,
   input  logic        run,
   output logic        strobe
);

   logic [31:0] rate;
   logic [31:0] count;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rate  <= 32'd0;
         count <= 32'd0;
      end
      else
      begin
         if (set_stb && (set_addr == ADDR_RATE))
         begin
            rate <= set_data;
         end
         if (!run || (count == rate))
         begin
            count <= 32'd0; // parked while the DSP is stopped
         end
         else
         begin
            count <= count + 32'd1;
         end
      end
   end

   // one pulse every rate+1 cycles
   assign strobe = run && (count == rate);

endmodule

//--- hdl/tx_time_base.sv
`timescale 1ns/1ps

module tx_time_base
   import tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        set_stb,
   input  logic [7:0]  set_addr,
   input  logic [31:0] set_data,
   input  logic [63:0] send_time,
   output logic [63:0] vita_time,
   output logic        now,
   output logic        early,
   output logic        late
);

   logic [31:0] time_hi; // staged upper half
   logic        load_hi;
   logic        commit;

   assign load_hi = set_stb && (set_addr == ADDR_TIME_HI);
   assign commit  = set_stb && (set_addr == ADDR_TIME_LO);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         time_hi <= 32'd0;
      end
      else if (load_hi)
      begin
         time_hi <= set_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vita_time <= 64'd0;
      end
      else if (commit)
      begin
         vita_time <= {time_hi, set_data};
      end
      else
      begin
         vita_time <= vita_time + 64'd1;
      end
   end

   // compare against the head word
   assign now   = (vita_time == send_time);
   assign late  = (vita_time > send_time);
   assign early = (vita_time < send_time);

endmodule

//--- hdl/tx_policy_reg.sv
`timescale 1ns/1ps

module tx_policy_reg
   import tx_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        set_stb,
   input  logic [7:0]  set_addr,
   input  logic [31:0] set_data,
   output logic        policy_wait,
   output logic        policy_next_packet,
   output logic        policy_next_burst,
   output logic        policy_changed
);

   logic [2:0] policy_q; // {next_burst, next_packet, wait}
   logic       hit;

   assign hit = set_stb && (set_addr == ADDR_POLICY);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         policy_q       <= 3'd0;
         policy_changed <= 1'b0;
      end
      else
      begin
         policy_changed <= hit; // one cycle, arms the seqnum clear
         if (hit)
         begin
            policy_q <= set_data[2:0];
         end
      end
   end

   // wait bit is kept but nothing acts on it yet
   assign policy_wait        = policy_q[0];
   assign policy_next_packet = policy_q[1];
   assign policy_next_burst  = policy_q[2];

endmodule

//--- hdl/tx_pkg.sv
package tx_pkg;

   // settings bus addresses
   localparam logic [7:0] ADDR_POLICY  = 8'd0;
   localparam logic [7:0] ADDR_RATE    = 8'd1;
   localparam logic [7:0] ADDR_TIME_HI = 8'd2;
   localparam logic [7:0] ADDR_TIME_LO = 8'd3; // commits the 64-bit load

   localparam int SEQ_W = 12;

   // error and ack kinds, upper word of the report code
   localparam logic [31:0] KIND_EOB_ACK            = 32'd1;
   localparam logic [31:0] KIND_UNDERRUN           = 32'd2;
   localparam logic [31:0] KIND_SEQ_ERROR          = 32'd4;
   localparam logic [31:0] KIND_TIME_ERROR         = 32'd8;
   localparam logic [31:0] KIND_UNDERRUN_MIDPKT    = 32'd16; // reserved
   localparam logic [31:0] KIND_SEQ_ERROR_MIDBURST = 32'd32;

   // one word from the deframer, msb first
   typedef struct packed {
      logic             odd;       // final word carries one sample only
      logic             send_at;   // hold until send_time
      logic             eob;
      logic             eop;
      logic [SEQ_W-1:0] seqnum;
      logic [31:0]      sid;
      logic [63:0]      send_time;
      logic [31:0]      sample0;
      logic [31:0]      sample1;
   } tx_sample_t;

   typedef struct packed {
      logic [31:0]      kind;
      logic [19:0]      zero;
      logic [SEQ_W-1:0] seqnum;
   } tx_err_plain_t;

   // sequence errors also carry what was expected
   typedef struct packed {
      logic [31:0]      kind;
      logic [3:0]       zero_hi;
      logic [SEQ_W-1:0] expected;
      logic [3:0]       zero_lo;
      logic [SEQ_W-1:0] received;
   } tx_err_seq_t;

   typedef union packed {
      tx_err_plain_t plain;
      tx_err_seq_t   seq;
   } tx_err_code_u;

   typedef struct packed {
      logic         valid;
      tx_err_code_u code;
   } tx_ack_t;

   typedef enum logic [1:0] {
      IDLE,
      SAMP0,
      SAMP1,
      ERROR
   } tx_ctrl_state_e;

endpackage
